// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := pwm_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Run ended without a result"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/pwm_assertions.sv ====
// Sampled on rising mclk; bus checks are held off while h_reset_n is low
`default_nettype none
`timescale 1ns/1ps

module pwm_assertions import pwm_pkg::*; (
  input logic                    mclk,
  input logic                    h_reset_n,
  input logic                    reg_cs,
  input logic                    reg_ack,
  input logic [PWM_CHANNELS-1:0] pwm_out
);

  // ------------------------------------------------
  // Register bus acknowledge
  // ------------------------------------------------
  // Single-cycle ack pulse
  ack_pulse: assert property (@(posedge mclk) disable iff (!h_reset_n)
    reg_ack |=> !reg_ack)
    else $error("reg_ack stayed high for two cycles");

  // Ack answers a chip select from the edge before
  ack_after_cs: assert property (@(posedge mclk) disable iff (!h_reset_n)
    $rose(reg_ack) |-> $past(reg_cs))
    else $error("reg_ack rose without reg_cs");

  // ------------------------------------------------
  // Outputs
  // ------------------------------------------------
  // All channels low in reset
  out_in_reset: assert property (@(posedge mclk) !h_reset_n |-> (pwm_out == '0))
    else $error("pwm_out not zero during reset");

endmodule : pwm_assertions

bind pwm_top pwm_assertions u_pwm_assertions (
  .mclk      (mclk),
  .h_reset_n (h_reset_n),
  .reg_cs    (reg_cs),
  .reg_ack   (reg_ack),
  .pwm_out   (pwm_out)
);

`default_nettype wire

// ==== bench/pwm_tb.sv ====
// Trace is read from bench/pwm_trace.txt relative to the run directory; M checks assume fixed periods
`default_nettype none
`timescale 1ns/1ps

module pwm_tb import pwm_pkg::*; ();

  logic                    mclk;
  logic                    h_reset_n;
  logic                    reg_cs;
  logic                    reg_wr;
  logic [REG_ADDR_W-1:0]   reg_addr;
  logic [REG_DATA_W-1:0]   reg_wdata;
  logic [REG_BE_W-1:0]     reg_be;
  logic [REG_DATA_W-1:0]   reg_rdata;
  logic                    reg_ack;
  logic [PWM_CHANNELS-1:0] pwm_out;

  // Trace lines and run bookkeeping
  string lines [$];
  string test_name;
  int    errors;
  int    test_errs;
  int    tests_ok;
  int    tests_bad;
  bit    aborted;

  pwm_top pwm_top_i (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .reg_cs    (reg_cs),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_be    (reg_be),
    .reg_rdata (reg_rdata),
    .reg_ack   (reg_ack),
    .pwm_out   (pwm_out)
  );

  // 20 ns clock
  always #10 mclk = ~mclk;

  // ------------------------------------------------
  // Reporting
  // ------------------------------------------------
  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Mismatch %s %s: expected %0h actual %0h", test_name, what, exp, act);
    errors++;
    test_errs++;
  endtask

  // A stuck DUT ends the trace early
  task automatic report_timeout(input string what);
    $display("Timeout in %s: %s", test_name, what);
    errors++;
    test_errs++;
    aborted = 1'b1;
  endtask

  // Name comes from the T line that closes the test
  function automatic string next_test(input int from);
    string op;
    string nm;
    for (int i = from; i < lines.size(); i++) begin
      if ($sscanf(lines[i], "%s %s", op, nm) == 2 && op == "T") return nm;
    end
    return "unnamed";
  endfunction

  // ------------------------------------------------
  // Register bus master
  // ------------------------------------------------
  task automatic bus_access(input bit wr, input int addr, input logic [31:0] data,
                            input logic [REG_BE_W-1:0] be, output logic [31:0] rdata);
    int waited;
    reg_cs    = 1'b1;
    reg_wr    = wr;
    reg_addr  = REG_ADDR_W'(addr);
    reg_wdata = data;
    reg_be    = be;
    waited    = 0;
    // Ack and read data are stable at the falling edge
    do begin
      @(negedge mclk);
      waited++;
    end while (!reg_ack && waited < 20);
    rdata = reg_rdata;
    if (!reg_ack) report_timeout($sformatf("no reg_ack for address %0d in 20 cycles", addr));
    reg_cs = 1'b0;
    reg_wr = 1'b0;
    // Random idle gap
    repeat ($urandom % 4) @(negedge mclk);
  endtask

  // ------------------------------------------------
  // Waveform measurement
  // ------------------------------------------------
  // Counts samples at lvl including the current one
  task automatic count_run(input int ch, input bit lvl, input int limit, output int run);
    run = 1;
    @(negedge mclk);
    while (pwm_out[ch] == lvl && run <= limit) begin
      run++;
      @(negedge mclk);
    end
    if (run > limit) report_timeout($sformatf("pwm_out[%0d] stuck at %0d", ch, lvl));
  endtask

  task automatic measure(input int ch, input int hi, input int lo, input int periods,
                         input bit inv);
    int limit;
    int n_on;
    int n_off;
    int waited;
    bit on_lvl;
    bit prev;
    limit  = 4 * (hi + lo) + 20;
    // Level of the high part after polarity
    on_lvl = !inv;
    if (hi == 0 || lo == 0) begin
      // Degenerate period holds one level for the whole window
      n_on = 0;
      for (int i = 0; i < periods * (hi + lo); i++) begin
        @(negedge mclk);
        if (pwm_out[ch] == ((hi == 0) ? inv : on_lvl)) n_on++;
      end
      assert (n_on == periods * (hi + lo))
        else report_mismatch($sformatf("ch%0d cycles at fixed level", ch),
                             periods * (hi + lo), n_on);
    end else begin
      waited = 0;
      prev   = pwm_out[ch];
      @(negedge mclk);
      // Start of a high part
      while (!(prev != on_lvl && pwm_out[ch] == on_lvl) && waited < limit) begin
        prev = pwm_out[ch];
        @(negedge mclk);
        waited++;
      end
      if (!(prev != on_lvl && pwm_out[ch] == on_lvl)) begin
        report_timeout($sformatf("no active edge on pwm_out[%0d]", ch));
      end else begin
        for (int p = 0; p < periods && !aborted; p++) begin
          count_run(ch, on_lvl, limit, n_on);
          count_run(ch, !on_lvl, limit, n_off);
          assert (n_on == hi)
            else report_mismatch($sformatf("ch%0d high cycles", ch), hi, n_on);
          assert (n_off == lo)
            else report_mismatch($sformatf("ch%0d low cycles", ch), lo, n_off);
        end
      end
    end
  endtask

  // ------------------------------------------------
  // Trace player
  // ------------------------------------------------
  initial begin
    int          fd;
    int          n;
    int          a;
    int          b;
    int          c;
    int          d;
    int          e;
    string       line;
    string       op;
    logic [31:0] data;
    logic [31:0] rd;
    mclk      = 1'b0;
    h_reset_n = 1'b0;
    reg_cs    = 1'b0;
    reg_wr    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    reg_be    = '0;
    errors    = 0;
    test_errs = 0;
    tests_ok  = 0;
    tests_bad = 0;
    aborted   = 1'b0;
    void'($urandom(77805));

    fd = $fopen("bench/pwm_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open trace file bench/pwm_trace.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) != 0) lines.push_back(line);
      end
      $fclose(fd);
    end

    // Reset held for 10 cycles and released on a falling edge
    repeat (10) @(negedge mclk);
    h_reset_n = 1'b1;
    @(negedge mclk);

    test_name = next_test(0);
    assert (pwm_out == '0)
      else report_mismatch("pwm_out after reset", 32'd0, 32'(pwm_out));

    for (int i = 0; i < lines.size() && !aborted; i++) begin
      op = "";
      n  = $sscanf(lines[i], "%s", op);
      // Blank lines and comments
      if (n != 1 || op == "#") continue;
      if (op == "W") begin
        n = $sscanf(lines[i], "%s %h %h %h", op, a, data, b);
        bus_access(1'b1, a, data, REG_BE_W'(b), rd);
      end else if (op == "R") begin
        n = $sscanf(lines[i], "%s %h %h", op, a, data);
        bus_access(1'b0, a, '0, '0, rd);
        assert (rd == data)
          else report_mismatch($sformatf("read addr %0d", a), data, rd);
      end else if (op == "M") begin
        n = $sscanf(lines[i], "%s %d %d %d %d %d", op, a, b, c, d, e);
        measure(a, b, c, d, e[0]);
      end else if (op == "T") begin
        if (test_errs == 0) begin
          $display("Test %-14s passed", test_name);
          tests_ok++;
        end else begin
          $display("Test %-14s failed with %0d errors", test_name, test_errs);
          tests_bad++;
        end
        test_name = next_test(i + 1);
        test_errs = 0;
      end else begin
        $display("Unknown trace operation %s on line %0d", op, i + 1);
        errors++;
      end
    end

    // Test cut short by a timeout
    if (aborted) begin
      $display("Test %-14s failed, trace stopped after a timeout", test_name);
      tests_bad++;
    end

    $display("Tests passed: %0d, tests failed: %0d, errors: %0d", tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : pwm_tb

`default_nettype wire

// ==== bench/pwm_trace.txt ====
# W addr data be | R addr expected | M channel high low periods inverted | T test-name
# addr, data, be and expected are hex; M fields are decimal
R 0 00000000
R 1 00000000
R 2 00000000
R 3 00000000
R 4 00000000
R 5 00000000
R 6 00000000
R 7 00000000
T reset_values
W 2 aabbccdd f
W 2 11223344 5
R 2 aa22cc44
W 0 ffffffff f
R 0 00003f3f
W 0 00000000 f
T byte_enables
W 1 00030005 f
W 2 00070002 f
W 0 00000003 1
M 0 3 5 4 0
M 1 7 2 4 0
T two_channels
W 3 00040006 f
W 0 00000c04 3
M 2 4 6 3 1
M 0 0 8 2 0
M 3 0 8 2 1
T enable_invert
W 5 00000009 f
W 6 00060000 f
W 0 00000030 1
M 4 0 9 3 0
M 5 6 0 3 0
W 7 ffffffff f
R 7 00000000
R 0 00000c30
T edge_cases

// ==== hdl/gen_32b_reg.sv ====
// Byte-lane write register; lanes update only while cs is high and reset asynchronously to RESET_VAL
`default_nettype none
`timescale 1ns/1ps

module gen_32b_reg import pwm_pkg::*; #(
  parameter logic [REG_DATA_W-1:0] RESET_VAL = '0
) (
  input  logic                  mclk,
  input  logic                  h_reset_n,
  // Write strobe for this register
  input  logic                  cs,
  // Byte enables
  input  logic [REG_BE_W-1:0]   we,
  input  logic [REG_DATA_W-1:0] data_in,
  output logic [REG_DATA_W-1:0] data_out
);

  // Each byte lane has its own enable
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      data_out <= RESET_VAL;
    end else if (cs) begin
      for (int b = 0; b < REG_BE_W; b++) begin
        // Untouched lanes keep old value
        if (we[b]) begin
          data_out[8*b +: 8] <= data_in[8*b +: 8];
        end
      end
    end
  end

endmodule : gen_32b_reg

`default_nettype wire

// ==== hdl/pwm_cfg_if.sv ====
// Plain level signals holding register contents; no handshake and values may change at any edge
`default_nettype none
`timescale 1ns/1ps

interface pwm_cfg_if import pwm_pkg::*; ();

  // ------------------------------------------------
  // Per-channel control bits
  // ------------------------------------------------
  // One enable bit per channel
  logic [PWM_CHANNELS-1:0] chan_en;
  // 1 flips the output polarity
  logic [PWM_CHANNELS-1:0] chan_inv;

  // ------------------------------------------------
  // Per-channel periods
  // ------------------------------------------------
  // Active part of the period
  pwm_period_t             cfg_high [PWM_CHANNELS];
  // Inactive part of the period
  pwm_period_t             cfg_low  [PWM_CHANNELS];

  // Register file drives everything
  modport reg_side (
    output chan_en, chan_inv, cfg_high, cfg_low
  );

  // Generator only reads
  modport gen_side (
    input  chan_en, chan_inv, cfg_high, cfg_low
  );

endinterface : pwm_cfg_if

`default_nettype wire

// ==== hdl/pwm_gen.sv ====
// Period changes act at once with no reload boundary; high of zero gives a constant inactive level
`default_nettype none
`timescale 1ns/1ps

module pwm_gen import pwm_pkg::*; (
  input  logic                    mclk,
  input  logic                    h_reset_n,

  // Configuration from the register file
  pwm_cfg_if.gen_side             cfg,

  output logic [PWM_CHANNELS-1:0] pwm_out
);

  // ------------------------------------------------
  // One counter and output stage per channel
  // ------------------------------------------------
  for (genvar ch = 0; ch < PWM_CHANNELS; ch++) begin : g_chan
    // One extra bit so high+low cannot overflow
    logic [PWM_CNT_W:0] period;
    logic [PWM_CNT_W:0] cnt;
    logic               active;
    logic               out_q;

    assign period = {1'b0, cfg.cfg_high[ch]} + {1'b0, cfg.cfg_low[ch]};
    // Active while still inside the high part
    assign active = (cnt < {1'b0, cfg.cfg_high[ch]});

    // Counter runs 0 .. period-1
    always_ff @(posedge mclk or negedge h_reset_n) begin
      if (!h_reset_n) begin
        cnt <= '0;
      end else if (!cfg.chan_en[ch]) begin
        // Parked while disabled
        cnt <= '0;
      end else if (cnt + 1'b1 >= period) begin
        // Also catches a period shortened below cnt
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end

    // Registered output with polarity
    always_ff @(posedge mclk or negedge h_reset_n) begin
      if (!h_reset_n) begin
        out_q <= 1'b0;
      end else if (cfg.chan_en[ch]) begin
        out_q <= active ^ cfg.chan_inv[ch];
      end else begin
        // Idle level follows invert bit
        out_q <= cfg.chan_inv[ch];
      end
    end

    assign pwm_out[ch] = out_q;
  end

endmodule : pwm_gen

`default_nettype wire

// ==== hdl/pwm_pkg.sv ====
// Channel count and register map are fixed here; address 7 is unmapped and reads as zero
`default_nettype none

package pwm_pkg;

  // ------------------------------------------------
  // Sizes
  // ------------------------------------------------
  localparam int PWM_CHANNELS = 6;
  localparam int PWM_CNT_W    = 16;
  localparam int REG_ADDR_W   = 3;
  localparam int REG_DATA_W   = 32;
  localparam int REG_BE_W     = 4;

  // ------------------------------------------------
  // Register map
  // ------------------------------------------------
  // Global enable and invert bits
  localparam logic [REG_ADDR_W-1:0] PWM_REG_GLBL = 3'd0;
  // Channel n lives at PWM_REG_CH0 + n
  localparam logic [REG_ADDR_W-1:0] PWM_REG_CH0  = 3'd1;

  // Field positions inside the global register
  localparam int GLBL_EN_LSB  = 0;
  localparam int GLBL_INV_LSB = 8;

  // Period value counted in mclk cycles
  typedef logic [PWM_CNT_W-1:0] pwm_period_t;

endpackage : pwm_pkg

`default_nettype wire

// ==== hdl/pwm_reg.sv ====
// Ack one cycle after cs, then low for a cycle; writes land every edge with cs and wr high
`default_nettype none
`timescale 1ns/1ps

module pwm_reg import pwm_pkg::*; (
  input  logic                  mclk,
  input  logic                  h_reset_n,

  // Register bus
  input  logic                  reg_cs,
  input  logic                  reg_wr,
  input  logic [REG_ADDR_W-1:0] reg_addr,
  input  logic [REG_DATA_W-1:0] reg_wdata,
  input  logic [REG_BE_W-1:0]   reg_be,
  output logic [REG_DATA_W-1:0] reg_rdata,
  output logic                  reg_ack,

  // Configuration towards the generator
  pwm_cfg_if.reg_side           cfg
);

  // ------------------------------------------------
  // Address decode
  // ------------------------------------------------
  logic                    wr_en;
  logic                    glbl_sel;
  logic                    glbl_wr;
  logic [PWM_CHANNELS-1:0] chan_sel;
  logic [PWM_CHANNELS-1:0] chan_wr;

  // Register contents
  logic [REG_DATA_W-1:0]   glbl_q;
  logic [REG_DATA_W-1:0]   chan_q [PWM_CHANNELS];
  // Read mux result sampled with ack
  logic [REG_DATA_W-1:0]   reg_out;

  assign wr_en    = reg_cs & reg_wr;
  assign glbl_sel = (reg_addr == PWM_REG_GLBL);
  assign glbl_wr  = wr_en & glbl_sel;

  // Global register holding the enable and invert fields
  gen_32b_reg #(
    .RESET_VAL ('0)
  ) u_glbl_reg (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .cs        (glbl_wr),
    .we        (reg_be),
    .data_in   (reg_wdata),
    .data_out  (glbl_q)
  );

  assign cfg.chan_en  = glbl_q[GLBL_EN_LSB +: PWM_CHANNELS];
  assign cfg.chan_inv = glbl_q[GLBL_INV_LSB +: PWM_CHANNELS];

  // ------------------------------------------------
  // Channel registers
  // ------------------------------------------------
  for (genvar ch = 0; ch < PWM_CHANNELS; ch++) begin : g_chan
    // Channel n sits one address above the previous one
    assign chan_sel[ch] = (reg_addr == PWM_REG_CH0 + REG_ADDR_W'(ch));
    assign chan_wr[ch]  = wr_en & chan_sel[ch];

    gen_32b_reg #(
      .RESET_VAL ('0)
    ) u_chan_reg (
      .mclk      (mclk),
      .h_reset_n (h_reset_n),
      .cs        (chan_wr[ch]),
      .we        (reg_be),
      .data_in   (reg_wdata),
      .data_out  (chan_q[ch])
    );

    // Low period in lower half, high period in upper half
    assign cfg.cfg_low[ch]  = chan_q[ch][PWM_CNT_W-1:0];
    assign cfg.cfg_high[ch] = chan_q[ch][2*PWM_CNT_W-1:PWM_CNT_W];
  end

  // ------------------------------------------------
  // Read mux
  // ------------------------------------------------
  always_comb begin
    // Unmapped address falls through as zero
    reg_out = '0;
    if (glbl_sel) begin
      // Other global bits read back as zero
      reg_out[GLBL_EN_LSB +: PWM_CHANNELS]  = glbl_q[GLBL_EN_LSB +: PWM_CHANNELS];
      reg_out[GLBL_INV_LSB +: PWM_CHANNELS] = glbl_q[GLBL_INV_LSB +: PWM_CHANNELS];
    end
    for (int ch = 0; ch < PWM_CHANNELS; ch++) begin
      if (chan_sel[ch]) begin
        reg_out = chan_q[ch];
      end
    end
  end

  // Ack pulse with registered read data
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      reg_rdata <= '0;
      reg_ack   <= 1'b0;
    end else if (reg_cs && !reg_ack) begin
      reg_rdata <= reg_out;
      reg_ack   <= 1'b1;
    end else begin
      // Forced low for one cycle even if cs stays up
      reg_ack   <= 1'b0;
    end
  end

endmodule : pwm_reg

`default_nettype wire

// ==== hdl/pwm_top.sv ====
// Register bus and PWM outputs share mclk; no latency added beyond register file and generator
`default_nettype none
`timescale 1ns/1ps

module pwm_top import pwm_pkg::*; (
  input  logic                    mclk,
  input  logic                    h_reset_n,

  // ------------------------------------------------
  // Register bus
  // ------------------------------------------------
  input  logic                    reg_cs,
  input  logic                    reg_wr,
  input  logic [REG_ADDR_W-1:0]   reg_addr,
  input  logic [REG_DATA_W-1:0]   reg_wdata,
  input  logic [REG_BE_W-1:0]     reg_be,
  output logic [REG_DATA_W-1:0]   reg_rdata,
  output logic                    reg_ack,

  // ------------------------------------------------
  // PWM outputs
  // ------------------------------------------------
  output logic [PWM_CHANNELS-1:0] pwm_out
);

  // Config levels between register file and generator
  pwm_cfg_if cfg_if ();

  // Register file
  pwm_reg u_pwm_reg (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .reg_cs    (reg_cs),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_be    (reg_be),
    .reg_rdata (reg_rdata),
    .reg_ack   (reg_ack),
    .cfg       (cfg_if.reg_side)
  );

  // Waveform generator
  pwm_gen u_pwm_gen (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .cfg       (cfg_if.gen_side),
    .pwm_out   (pwm_out)
  );

endmodule : pwm_top

`default_nettype wire

// ==== src.f ====
hdl/pwm_pkg.sv
hdl/pwm_cfg_if.sv
hdl/gen_32b_reg.sv
hdl/pwm_reg.sv
hdl/pwm_gen.sv
hdl/pwm_top.sv
bench/pwm_assertions.sv
bench/pwm_tb.sv
